// ==== include/iwm_settings.svh ====
`ifndef IWM_SETTINGS_SVH
`define IWM_SETTINGS_SVH

`default_nettype none

// ====================
// Q7 stability filter
// ====================

// Q7 high cycles counted before write mode is confirmed
`define IWM_Q7_RISE_THRESH 8

// Q7 low cycles counted before write mode ends
// Long enough to ride through handshake polls
`define IWM_Q7_FALL_THRESH 100

// ====================
// Mode register
// ====================

// Latch, async and timer-off set after reset
`define IWM_MODE_RESET 8'h07

// ====================
// Write serializer
// ====================

// Bit-cell timer width, longest cell is 32 fclk
`define IWM_BITCELL_W 6

// Timer start value when write mode begins
`define IWM_FIRST_LOAD_START 14

`default_nettype wire

`endif

// ==== design/iwmPkg.sv ====
`default_nettype none

package iwmPkg;

	// ====================
	// State pseudo-register
	// ====================

	// Field order follows addr[3:1]
	// Phase bits at 0..3, then motor, drive, Q6, Q7
	typedef struct packed {
		logic       q7;
		logic       q6;
		logic       driveSelect;
		logic       motorOn;
		logic [3:0] phase;
	} stateRegT;

	// ====================
	// Mode register
	// ====================

	// Written by the CPU with motor off
	// Bits 4..0 show up in the status read
	typedef struct packed {
		logic spare;
		logic mzReset;
		logic test;
		logic clk8MHz;
		logic fast;
		logic timerOff;
		logic async;
		logic latch;
	} modeRegT;

	// ====================
	// Serializer flags
	// ====================

	// Both read back through the handshake register
	typedef struct packed {
		logic bufferEmpty;
		logic nUnderrun;
	} writeStatusT;

endpackage

`default_nettype wire

// ==== design/busDecoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module busDecoder import iwmPkg::*; (
	input  logic       fclk,
	input  logic       nRES,
	input  logic [3:0] addr,
	input  logic       nDeviceSelect,
	output stateRegT   state,
	output logic       writeStrobe
);

	// Select level from the previous cycle
	logic nDevSelPrev;

	// Write condition and its two delay stages
	logic writeCondNow;
	logic writeCondD1;
	logic writeCondD2;

	// ====================
	// State pseudo-register
	// ====================

	// Phase, motor and drive update by level during an access
	// Q6 and Q7 only on the select falling edge
	// Their two addresses differ in addr[0] alone
	always_ff @(posedge fclk or negedge nRES) begin
		if (!nRES) begin
			state       <= '0;
			nDevSelPrev <= 1'b1;
		end else begin
			nDevSelPrev <= nDeviceSelect;
			if (!nDeviceSelect) begin
				case (addr[3:1])
					3'd0: state.phase[0]    <= addr[0];
					3'd1: state.phase[1]    <= addr[0];
					3'd2: state.phase[2]    <= addr[0];
					3'd3: state.phase[3]    <= addr[0];
					3'd4: state.motorOn     <= addr[0];
					3'd5: state.driveSelect <= addr[0];
					default: ;
				endcase
			end
			if (nDevSelPrev && !nDeviceSelect) begin
				case (addr[3:1])
					3'd6: state.q6 <= addr[0];
					3'd7: state.q7 <= addr[0];
					default: ;
				endcase
			end
		end
	end

	// ====================
	// One-shot write strobe
	// ====================

	// Register write access with Q7 and Q6 both set
	assign writeCondNow = !nDeviceSelect && state.q7 && state.q6 && addr[0];

	// First stage lets dataIn settle
	// Second stage blocks the rest of the access
	always_ff @(posedge fclk or negedge nRES) begin
		if (!nRES) begin
			writeCondD1 <= 1'b0;
			writeCondD2 <= 1'b0;
		end else begin
			writeCondD1 <= writeCondNow;
			writeCondD2 <= writeCondD1;
		end
	end

	// Exactly one cycle per bus access
	assign writeStrobe = writeCondD1 && !writeCondD2;

endmodule

`default_nettype wire

// ==== design/q7Filter.sv ====
`timescale 1ns/1ps
`include "iwm_settings.svh"
`default_nettype none

module q7Filter import iwmPkg::*; (
	input  logic     fclk,
	input  logic     nRES,
	input  stateRegT state,
	output logic     q7Stable
);

	localparam int RISE_THRESH = `IWM_Q7_RISE_THRESH;
	localparam int FALL_THRESH = `IWM_Q7_FALL_THRESH;
	localparam int RISE_W      = $clog2(RISE_THRESH + 1);
	localparam int FALL_W      = $clog2(FALL_THRESH + 1);

	// Run-length counters for each Q7 level
	logic [RISE_W-1:0] riseCtr;
	logic [FALL_W-1:0] fallCtr;

	// ====================
	// Hysteresis filter
	// ====================

	// Rise needs a long high run, so bus glitches are ignored
	// Fall needs a longer low run
	// Handshake polls dip Q7 briefly and must not end write mode
	always_ff @(posedge fclk or negedge nRES) begin
		if (!nRES) begin
			riseCtr  <= '0;
			fallCtr  <= '0;
			q7Stable <= 1'b0;
		end else if (state.q7) begin
			fallCtr <= '0;
			if (!q7Stable) begin
				if (riseCtr < RISE_W'(RISE_THRESH))
					riseCtr <= riseCtr + 1'b1;
				else
					q7Stable <= 1'b1;
			end
		end else begin
			riseCtr <= '0;
			if (q7Stable) begin
				if (fallCtr < FALL_W'(FALL_THRESH))
					fallCtr <= fallCtr + 1'b1;
				else
					q7Stable <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

// ==== design/writeSerializer.sv ====
`timescale 1ns/1ps
`include "iwm_settings.svh"
`default_nettype none

module writeSerializer import iwmPkg::*; (
	input  logic        fclk,
	input  logic        nRES,
	input  logic [7:0]  dataIn,
	input  stateRegT    state,
	input  logic        writeStrobe,
	input  logic        q7Stable,
	output modeRegT     mode,
	output writeStatusT status,
	output logic        wrData
);

	localparam int BITCELL_W = `IWM_BITCELL_W;
	localparam logic [BITCELL_W-1:0] FIRST_LOAD = BITCELL_W'(`IWM_FIRST_LOAD_START);

	logic [7:0]           buffer;
	logic [7:0]           shifter;
	logic [BITCELL_W-1:0] bitTimer;
	logic [BITCELL_W-1:0] bitCellMax;
	logic [2:0]           bitCounter;
	logic                 q7StablePrev;
	logic                 loadMode;
	logic                 loadBuffer;
	logic                 writeStart;
	logic                 cellEnd;
	logic                 byteEnd;

	// Strobe goes to mode with motor off, else to the buffer
	// Buffer writes are refused once underrun is flagged
	assign loadMode   = writeStrobe && !state.motorOn;
	assign loadBuffer = writeStrobe && state.motorOn && status.nUnderrun;

	// Cell length minus one, timer counts 0..max
	always_comb begin
		case ({mode.fast, mode.clk8MHz})
			2'b00:   bitCellMax = BITCELL_W'(27);
			2'b01:   bitCellMax = BITCELL_W'(31);
			2'b10:   bitCellMax = BITCELL_W'(13);
			default: bitCellMax = BITCELL_W'(15);
		endcase
	end

	assign writeStart = q7Stable && !q7StablePrev;
	// First load value can exceed a fast cell, so roll over on >=
	assign cellEnd    = q7Stable && !writeStart && (bitTimer >= bitCellMax);
	assign byteEnd    = cellEnd && (bitCounter == 3'd7);

	// ====================
	// Buffer and shifter
	// ====================

	always_ff @(posedge fclk) begin
		if (loadBuffer)
			buffer <= dataIn;
	end

	// All ones at start, toggle point already passed so nothing is emitted
	always_ff @(posedge fclk) begin
		if (writeStart)
			shifter <= 8'hFF;
		else if (byteEnd && !status.bufferEmpty)
			shifter <= buffer;
		else if (cellEnd && !byteEnd)
			shifter <= {shifter[6:0], 1'b0};
	end

	// ====================
	// Control and timing
	// ====================

	always_ff @(posedge fclk or negedge nRES) begin
		if (!nRES) begin
			mode         <= `IWM_MODE_RESET;
			status       <= '{bufferEmpty: 1'b1, nUnderrun: 1'b1};
			bitTimer     <= '0;
			bitCounter   <= 3'd7;
			q7StablePrev <= 1'b0;
			wrData       <= 1'b0;
		end else begin
			q7StablePrev <= q7Stable;
			if (loadMode)
				mode <= dataIn;
			if (!q7Stable) begin
				// Idle level outside write mode
				status.nUnderrun <= 1'b1;
				wrData           <= 1'b0;
			end else if (writeStart) begin
				bitTimer   <= FIRST_LOAD;
				bitCounter <= 3'd7;
			end else begin
				if (cellEnd) begin
					bitTimer   <= '0;
					bitCounter <= bitCounter + 1'b1;
					// Byte boundary with nothing queued
					if (byteEnd && status.bufferEmpty)
						status.nUnderrun <= 1'b0;
				end else begin
					bitTimer <= bitTimer + 1'b1;
				end
				// One transition per 1 bit, stopped at once on underrun
				if (!status.nUnderrun)
					wrData <= 1'b0;
				else if (bitTimer == BITCELL_W'(1) && shifter[7])
					wrData <= !wrData;
			end
			// CPU load wins over a same-cycle byte take
			if (loadBuffer)
				status.bufferEmpty <= 1'b0;
			else if (byteEnd)
				status.bufferEmpty <= 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== design/driveOutputs.sv ====
`timescale 1ns/1ps
`default_nettype none

module driveOutputs import iwmPkg::*; (
	input  stateRegT    state,
	input  modeRegT     mode,
	input  writeStatusT status,
	input  logic        q7Stable,
	input  logic        sense,
	output logic [7:0]  dataOut,
	output logic [3:0]  phase,
	output logic        nEnbl1,
	output logic        nEnbl2,
	output logic        nWrReq,
	output logic        q7Out
);

	// Any drive enable active
	logic enableActive;

	// ====================
	// Drive lines
	// ====================

	// Enables are active low, one per drive
	assign nEnbl1       = !(state.motorOn && !state.driveSelect);
	assign nEnbl2       = !(state.motorOn && state.driveSelect);
	assign enableActive = !nEnbl1 || !nEnbl2;

	// Filtered Q7 keeps bus glitches off the request line
	// Request drops as soon as underrun is flagged
	assign nWrReq = !(q7Stable && status.nUnderrun && enableActive);

	// Phase lines and raw Q7 go straight to the drive
	assign phase = state.phase;
	assign q7Out = state.q7;

	// ====================
	// CPU read mux
	// ====================

	// Selected by Q7 and Q6
	// Read data and the write selection both return all ones
	always_comb begin
		case ({state.q7, state.q6})
			2'b01:   dataOut = {sense, 1'b0, enableActive, mode[4:0]};
			2'b10:   dataOut = {status.bufferEmpty, status.nUnderrun, 6'b000000};
			default: dataOut = 8'hFF;
		endcase
	end

endmodule

`default_nettype wire

// ==== design/iwm.sv ====
`timescale 1ns/1ps
`default_nettype none

module iwm import iwmPkg::*; (
	input  logic       fclk,
	input  logic       nRES,
	input  logic [3:0] addr,
	input  logic       nDeviceSelect,
	input  logic [7:0] dataIn,
	output logic [7:0] dataOut,
	input  logic       sense,
	output logic       wrData,
	output logic [3:0] phase,
	output logic       nWrReq,
	output logic       nEnbl1,
	output logic       nEnbl2,
	output logic       q7Out
);

	stateRegT    state;
	logic        writeStrobe;
	logic        q7Stable;
	modeRegT     mode;
	writeStatusT status;

	// ====================
	// Bus side
	// ====================

	busDecoder busDecoder_i (
		.fclk          (fclk),
		.nRES          (nRES),
		.addr          (addr),
		.nDeviceSelect (nDeviceSelect),
		.state         (state),
		.writeStrobe   (writeStrobe)
	);

	// Write mode level for the serializer and outputs
	q7Filter q7Filter_i (
		.fclk     (fclk),
		.nRES     (nRES),
		.state    (state),
		.q7Stable (q7Stable)
	);

	// ====================
	// Write path
	// ====================

	writeSerializer writeSerializer_i (
		.fclk        (fclk),
		.nRES        (nRES),
		.dataIn      (dataIn),
		.state       (state),
		.writeStrobe (writeStrobe),
		.q7Stable    (q7Stable),
		.mode        (mode),
		.status      (status),
		.wrData      (wrData)
	);

	// Drive lines and CPU read data
	driveOutputs driveOutputs_i (
		.state    (state),
		.mode     (mode),
		.status   (status),
		.q7Stable (q7Stable),
		.sense    (sense),
		.dataOut  (dataOut),
		.phase    (phase),
		.nEnbl1   (nEnbl1),
		.nEnbl2   (nEnbl2),
		.nWrReq   (nWrReq),
		.q7Out    (q7Out)
	);

endmodule

`default_nettype wire

// ==== verification/clockGen.sv ====
`timescale 1ns/1ps
`default_nettype none

module clockGen (
	output logic fclk,
	output logic nRES
);

	// 100 MHz, 10 ns period
	initial begin
		fclk = 1'b0;
		forever #5 fclk = ~fclk;
	end

	// Reset held low for 8 rising edges
	initial begin
		nRES = 1'b0;
		repeat (8) @(posedge fclk);
		nRES <= 1'b1;
	end

endmodule

`default_nettype wire

// ==== verification/iwmChecker.sv ====
`timescale 1ns/1ps
`default_nettype none

module iwmChecker (
	input logic fclk,
	input logic nRES,
	input logic wrData,
	input logic nWrReq,
	input logic nEnbl1,
	input logic nEnbl2
);

	// Failed assertion count, read by the testbench at the end
	int failCount = 0;

	// ====================
	// Drive line rules
	// ====================

	// Once the request has been released for two cycles, write data idles low
	// The serializer needs one edge to force it low after underrun
	wrDataIdle: assert property (@(posedge fclk) disable iff (!nRES)
		(nWrReq && $past(nWrReq) && $past(nWrReq, 2)) |-> (!wrData && $stable(wrData)))
	else begin
		failCount++;
		$error("wrData moved while nWrReq was high");
	end

	// Only one drive enabled at a time
	oneDrive: assert property (@(posedge fclk) disable iff (!nRES)
		(nEnbl1 || nEnbl2))
	else begin
		failCount++;
		$error("both drive enables low");
	end

	// Write request needs a selected drive
	wrReqNeedsDrive: assert property (@(posedge fclk) disable iff (!nRES)
		!nWrReq |-> (!nEnbl1 || !nEnbl2))
	else begin
		failCount++;
		$error("nWrReq low with no drive enabled");
	end

endmodule

`default_nettype wire

// ==== verification/iwmTb.sv ====
`timescale 1ns/1ps
`include "iwm_settings.svh"
`default_nettype none

module iwmTb;

	localparam int NUM_BYTES = 4;
	localparam int POLL_LIMIT = 500;
	localparam logic [7:0] MODE_RESET = `IWM_MODE_RESET;

	logic       fclk;
	logic       nRES;
	logic [3:0] addr;
	logic       nDeviceSelect;
	logic [7:0] dataIn;
	logic [7:0] dataOut;
	logic       sense;
	logic       wrData;
	logic [3:0] phase;
	logic       nWrReq;
	logic       nEnbl1;
	logic       nEnbl2;
	logic       q7Out;

	int          mismatchCount = 0;
	int          timeoutCount = 0;
	logic [31:0] rngState = 32'd4;

	// Activity counters, updated on the falling edge
	int   toggleCount = 0;
	int   anyToggleCount = 0;
	int   wrReqLowCount = 0;
	logic wrDataPrev = 1'b0;
	logic nWrReqPrev = 1'b1;

	clockGen clockGen_i (
		.fclk (fclk),
		.nRES (nRES)
	);

	iwm iwm_i (
		.fclk          (fclk),
		.nRES          (nRES),
		.addr          (addr),
		.nDeviceSelect (nDeviceSelect),
		.dataIn        (dataIn),
		.dataOut       (dataOut),
		.sense         (sense),
		.wrData        (wrData),
		.phase         (phase),
		.nWrReq        (nWrReq),
		.nEnbl1        (nEnbl1),
		.nEnbl2        (nEnbl2),
		.q7Out         (q7Out)
	);

	bind iwm iwmChecker iwmChecker_i (
		.fclk   (fclk),
		.nRES   (nRES),
		.wrData (wrData),
		.nWrReq (nWrReq),
		.nEnbl1 (nEnbl1),
		.nEnbl2 (nEnbl2)
	);

	// ====================
	// Helpers
	// ====================

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic nextByte(output logic [7:0] value);
		rngState = xorshift32(rngState);
		value = rngState[7:0];
	endtask

	function automatic int countOnes(input logic [7:0] value);
		int total;
		total = 0;
		for (int b = 0; b < 8; b++) begin
			if (value[b])
				total++;
		end
		return total;
	endfunction

	// Write toggles count only while the request was active
	always @(negedge fclk) begin
		if (nRES) begin
			if (wrData !== wrDataPrev) begin
				anyToggleCount++;
				if (!nWrReqPrev)
					toggleCount++;
			end
			if (!nWrReq)
				wrReqLowCount++;
			wrDataPrev <= wrData;
			nWrReqPrev <= nWrReq;
		end
	end

	// One bus access, select low for lowCycles edges, one idle cycle follows
	task automatic busAccess(input logic [3:0] a, input logic [7:0] d, input int lowCycles);
		@(posedge fclk);
		addr          <= a;
		dataIn        <= d;
		nDeviceSelect <= 1'b0;
		repeat (lowCycles) @(posedge fclk);
		nDeviceSelect <= 1'b1;
	endtask

	task automatic checkValue(input string what, input logic [7:0] got,
		input logic [7:0] expected);
		assert (got === expected)
		else begin
			mismatchCount++;
			$display("Mismatch at %0t ns: %s is %h, expected %h", $time, what, got, expected);
		end
	endtask

	task automatic waitForReset();
		int cycles;
		cycles = 0;
		while (nRES !== 1'b1 && cycles < 100) begin
			@(posedge fclk);
			cycles++;
		end
		if (nRES !== 1'b1) begin
			timeoutCount++;
			$display("Reset was never released");
		end
	endtask

	// Poll one handshake bit, Q7 set and Q6 clear
	task automatic waitHandshakeBit(input int bitIndex, input logic level, input string what);
		int cycles;
		cycles = 0;
		@(negedge fclk);
		while (dataOut[bitIndex] !== level && cycles < POLL_LIMIT) begin
			@(negedge fclk);
			cycles++;
		end
		if (dataOut[bitIndex] !== level) begin
			timeoutCount++;
			$display("Timed out at %0t ns waiting for %s", $time, what);
		end
	endtask

	// ====================
	// Stimulus
	// ====================

	initial begin
		logic [7:0] modeByte;
		logic [7:0] fastMode;
		logic [7:0] lateByte;
		logic [7:0] dataBytes [NUM_BYTES];
		logic [3:0] phaseExp;
		int         expectedToggles;
		int         togglesAtStart;
		int         lowAtStart;
		int         checkerFails;

		addr          <= 4'h0;
		nDeviceSelect <= 1'b1;
		dataIn        <= 8'h00;
		sense         <= 1'b1;
		waitForReset();

		// Reset state
		@(negedge fclk);
		checkValue("phase after reset", {4'h0, phase}, 8'h00);
		checkValue("enables after reset", {6'b0, nEnbl2, nEnbl1}, 8'h03);
		checkValue("nWrReq after reset", {7'b0, nWrReq}, 8'h01);
		checkValue("wrData after reset", {7'b0, wrData}, 8'h00);
		// Q6 set, Q7 clear selects status
		busAccess(4'hD, 8'h00, 7);
		@(negedge fclk);
		checkValue("status after reset", dataOut, {sense, 2'b00, MODE_RESET[4:0]});

		// Phase bits set then cleared one by one
		phaseExp = 4'h0;
		for (int i = 0; i < 4; i++) begin
			busAccess(4'(2 * i + 1), 8'h00, 7);
			phaseExp[i] = 1'b1;
			@(negedge fclk);
			checkValue("phase set", {4'h0, phase}, {4'h0, phaseExp});
		end
		for (int i = 0; i < 4; i++) begin
			busAccess(4'(2 * i), 8'h00, 7);
			phaseExp[i] = 1'b0;
			@(negedge fclk);
			checkValue("phase cleared", {4'h0, phase}, {4'h0, phaseExp});
		end

		// Motor on, drive 1 then drive 2, then motor off
		busAccess(4'h9, 8'h00, 7);
		busAccess(4'hA, 8'h00, 7);
		@(negedge fclk);
		checkValue("enables drive 1", {6'b0, nEnbl2, nEnbl1}, 8'h02);
		busAccess(4'hB, 8'h00, 7);
		@(negedge fclk);
		checkValue("enables drive 2", {6'b0, nEnbl2, nEnbl1}, 8'h01);
		busAccess(4'h8, 8'h00, 7);
		@(negedge fclk);
		checkValue("enables motor off", {6'b0, nEnbl2, nEnbl1}, 8'h03);

		// Mode write, Q6 already set so raising Q7 on the odd address stores it
		nextByte(modeByte);
		busAccess(4'hF, modeByte, 7);
		busAccess(4'hE, 8'h00, 7);
		@(negedge fclk);
		checkValue("status after mode write", dataOut, {sense, 2'b00, modeByte[4:0]});
		@(posedge fclk);
		sense <= ~sense;
		@(negedge fclk);
		checkValue("status sense bit", dataOut, {sense, 2'b00, modeByte[4:0]});
		busAccess(4'h9, 8'h00, 7);
		busAccess(4'hA, 8'h00, 7);
		@(negedge fclk);
		checkValue("status motor on", dataOut, {sense, 2'b01, modeByte[4:0]});

		// Fast 7 MHz mode, 14 fclk per cell
		nextByte(fastMode);
		fastMode = {3'b000, 2'b01, fastMode[2:0]};
		busAccess(4'h8, 8'h00, 7);
		busAccess(4'hF, fastMode, 7);
		busAccess(4'hE, 8'h00, 7);
		busAccess(4'h9, 8'h00, 7);
		@(negedge fclk);
		checkValue("status fast mode", dataOut, {sense, 2'b01, fastMode[4:0]});

		// ====================
		// Byte serialization
		// ====================

		expectedToggles = 0;
		for (int n = 0; n < NUM_BYTES; n++) begin
			nextByte(dataBytes[n]);
			expectedToggles += countOnes(dataBytes[n]);
		end
		@(posedge fclk);
		togglesAtStart = toggleCount;
		// First byte goes in with the Q7 rise
		busAccess(4'hF, dataBytes[0], 7);
		busAccess(4'hC, 8'h00, 7);
		@(negedge fclk);
		checkValue("nWrReq in write mode", {7'b0, nWrReq}, 8'h00);
		for (int n = 1; n < NUM_BYTES; n++) begin
			waitHandshakeBit(7, 1'b1, "buffer empty");
			busAccess(4'hD, dataBytes[n], 7);
			busAccess(4'hC, 8'h00, 7);
		end

		// Underrun after the last byte
		waitHandshakeBit(6, 1'b0, "underrun");
		@(negedge fclk);
		checkValue("nWrReq at underrun", {7'b0, nWrReq}, 8'h01);
		@(posedge fclk);
		checkValue("toggles before underrun", 8'(toggleCount - togglesAtStart),
			8'(expectedToggles));
		// Late data write must be refused
		nextByte(lateByte);
		busAccess(4'hD, lateByte, 7);
		busAccess(4'hC, 8'h00, 7);
		@(negedge fclk);
		checkValue("handshake after late write", dataOut, 8'h80);
		checkValue("wrData in underrun", {7'b0, wrData}, 8'h00);

		// Leave write mode and let the filter fall
		busAccess(4'hE, 8'h00, 7);
		repeat (`IWM_Q7_FALL_THRESH + 10) @(posedge fclk);

		// ====================
		// Q7 glitch
		// ====================

		togglesAtStart = anyToggleCount;
		lowAtStart = wrReqLowCount;
		busAccess(4'hF, 8'h00, 1);
		@(negedge fclk);
		checkValue("q7Out after set", {7'b0, q7Out}, 8'h01);
		// Five cycles of Q7 high in total
		repeat (3) @(posedge fclk);
		busAccess(4'hE, 8'h00, 7);
		@(negedge fclk);
		checkValue("q7Out after clear", {7'b0, q7Out}, 8'h00);
		repeat (30) @(posedge fclk);
		checkValue("wrData toggles in glitch", 8'(anyToggleCount - togglesAtStart), 8'h00);
		checkValue("nWrReq low cycles in glitch", 8'(wrReqLowCount - lowAtStart), 8'h00);

		@(posedge fclk);
		checkerFails = iwm_i.iwmChecker_i.failCount;
		$display("Errors: %0d mismatches, %0d timeouts, %0d assertion failures",
			mismatchCount, timeoutCount, checkerFails);
		if (mismatchCount + timeoutCount + checkerFails == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+include
design/iwmPkg.sv
design/busDecoder.sv
design/q7Filter.sv
design/writeSerializer.sv
design/driveOutputs.sv
design/iwm.sv
verification/clockGen.sv
verification/iwmChecker.sv
verification/iwmTb.sv

// ==== run.sh ====
#!/bin/sh
# Build the IWM write path with Verilator and run the testbench
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module iwmTb -f compile.f -o iwmSim

./obj_dir/iwmSim | tee sim.log

if grep -q "Simulation PASSED" sim.log; then
	exit 0
fi
echo "Testbench reported failure, see sim.log"
exit 1
